//--- dv/hdmi_to_vga_tb.sv
////////////////////////////////////////
// HDMI to VGA testbench
// Replays a run-length trace with channel
// skew, checks pixels, sync and islands
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module hdmi_to_vga_tb
	import hdmi_rx_pkg::*;
();

	// Cycles allowed for expected outputs to drain
	localparam int DRAIN_LIMIT = 400;
	// Upper bound on trace records
	localparam int REC_LIMIT = 2000;

	logic			i_clk;
	logic			i_rst;
	logic [SYM_W-1:0]	i_hdmi_red, i_hdmi_grn, i_hdmi_blu;
	logic			o_pix_valid, o_vsync, o_hsync;
	logic [PIX_W-1:0]	o_vga_red, o_vga_green, o_vga_blue;
	logic			o_di_valid, o_di_hdr, o_di_last;
	logic [PIX_W-1:0]	o_di_data;

	// Ordered expectations
	logic [3*PIX_W-1:0]	pix_q [$];
	logic [1:0]		sync_q [$];
	logic [PIX_W+1:0]	byte_q [$];
	logic [3*PIX_W-1:0]	exp_pix;
	logic [1:0]		exp_sync;
	logic [PIX_W+1:0]	exp_byte;

	// Channel histories, index is age in cycles
	logic [SYM_W-1:0]	red_hist [3], grn_hist [3], blu_hist [3];
	int			red_dly, grn_dly, blu_dly;

	int			fd, code, rec_count;
	int			check_count, error_count, test_count, test_errors;
	logic [7:0]		op;
	logic [8*128-1:0]	line_buf;
	logic			trace_done, run_aborted;
	logic			prev_valid;
	logic [1:0]		period_sync;

	hdmi_to_vga #(
		.OPT_DATA_ISLAND(1'b1)
	) UUT (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_hdmi_red(i_hdmi_red), .i_hdmi_grn(i_hdmi_grn), .i_hdmi_blu(i_hdmi_blu),
		.o_pix_valid(o_pix_valid), .o_vsync(o_vsync), .o_hsync(o_hsync),
		.o_vga_red(o_vga_red), .o_vga_green(o_vga_green), .o_vga_blue(o_vga_blue),
		.o_di_valid(o_di_valid), .o_di_hdr(o_di_hdr), .o_di_last(o_di_last),
		.o_di_data(o_di_data)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
	begin
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	end
	endtask

	// One cycle of stimulus, each channel taken from its own delay tap
	task automatic drive_cycle(input logic [SYM_W-1:0] red, grn, blu);
	begin
		@(posedge i_clk);
		for (int k = 2; k > 0; k--)
		begin
			red_hist[k] = red_hist[k-1];
			grn_hist[k] = grn_hist[k-1];
			blu_hist[k] = blu_hist[k-1];
		end
		red_hist[0] = red;
		grn_hist[0] = grn;
		blu_hist[0] = blu;
		i_hdmi_red <= red_hist[red_dly];
		i_hdmi_grn <= grn_hist[grn_dly];
		i_hdmi_blu <= blu_hist[blu_dly];
	end
	endtask

	// Wait until every expected output has been seen
	task automatic end_test(input int id);
		int waited;
	begin
		waited = 0;
		while ((pix_q.size() + sync_q.size() + byte_q.size()) != 0 && waited < DRAIN_LIMIT)
		begin
			@(posedge i_clk);
			waited++;
		end
		if ((pix_q.size() + sync_q.size() + byte_q.size()) != 0)
		begin
			$display("Timeout in test %0d: %0d pixels, %0d sync values, %0d bytes never came",
				id, pix_q.size(), sync_q.size(), byte_q.size());
			run_aborted = 1'b1;
			trace_done = 1'b1;
		end
		test_count++;
		$display("Test %0d done with %0d errors", id, error_count - test_errors);
		test_errors = error_count;
	end
	endtask

	task automatic run_record(input logic [7:0] rec);
		int cnt, a, b, c;
	begin
		case (rec)
		"#": code = $fgets(line_buf, fd);
		"K": code = $fscanf(fd, "%d %d %d", red_dly, grn_dly, blu_dly);
		"R":
		begin
			code = $fscanf(fd, "%d %h %h %h", cnt, a, b, c);
			repeat (cnt) drive_cycle(a[SYM_W-1:0], b[SYM_W-1:0], c[SYM_W-1:0]);
		end
		"E":
		begin
			code = $fscanf(fd, "%d %h %h %h", cnt, a, b, c);
			repeat (cnt) pix_q.push_back({a[7:0], b[7:0], c[7:0]});
		end
		"S":
		begin
			code = $fscanf(fd, "%d %d", a, b);
			sync_q.push_back({a[0], b[0]});
		end
		"D":
		begin
			code = $fscanf(fd, "%d %d %h %d", cnt, a, b, c);
			repeat (cnt) byte_q.push_back({a[0], b[7:0], c[0]});
		end
		"T":
		begin
			code = $fscanf(fd, "%d", a);
			end_test(a);
		end
		default:
		begin
			$display("Unknown record type in the trace file");
			error_count++;
			trace_done = 1'b1;
		end
		endcase
	end
	endtask

	////////////////////////////////////////
	// Output monitors
	////////////////////////////////////////
	always @(negedge i_clk)
	begin
		if (!i_rst)
		begin
			if (o_pix_valid && pix_q.size() == 0)
			begin
				error_count++;
				$display("Unexpected pixel at %0t ns while none was expected", $time);
			end else if (o_pix_valid)
			begin
				exp_pix = pix_q.pop_front();
				check_value({o_vga_red, o_vga_green, o_vga_blue}, exp_pix, "pixel rgb");
			end
			// Sync held during the period
			if (o_pix_valid)
				period_sync = {o_vsync, o_hsync};
			// Falling valid ends the period
			if (prev_valid && !o_pix_valid && sync_q.size() == 0)
			begin
				error_count++;
				$display("Video period ended at %0t ns without a sync expectation", $time);
			end else if (prev_valid && !o_pix_valid)
			begin
				exp_sync = sync_q.pop_front();
				check_value(period_sync, exp_sync, "vsync and hsync");
			end
			prev_valid = o_pix_valid;
			// Island byte stream
			if (o_di_valid && byte_q.size() == 0)
			begin
				error_count++;
				$display("Unexpected island byte at %0t ns", $time);
			end else if (o_di_valid)
			begin
				exp_byte = byte_q.pop_front();
				check_value({o_di_hdr, o_di_data, o_di_last}, exp_byte, "island byte");
			end else if (o_di_last)
			begin
				error_count++;
				$display("Island last flag raised without valid at %0t ns", $time);
			end
		end
	end

	////////////////////////////////////////
	// Trace replay
	////////////////////////////////////////
	initial
	begin
		i_rst = 1'b1;
		i_hdmi_red = CTL_CODE_0;
		i_hdmi_grn = CTL_CODE_0;
		i_hdmi_blu = CTL_CODE_0;
		for (int k = 0; k < 3; k++)
		begin
			red_hist[k] = CTL_CODE_0;
			grn_hist[k] = CTL_CODE_0;
			blu_hist[k] = CTL_CODE_0;
		end
		red_dly = 0;
		grn_dly = 0;
		blu_dly = 0;
		check_count = 0;
		error_count = 0;
		test_count = 0;
		test_errors = 0;
		run_aborted = 1'b0;
		prev_valid = 1'b0;
		period_sync = 2'b00;
		fd = $fopen("dv/hdmi_to_vga_trace.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the trace file dv/hdmi_to_vga_trace.txt");
			run_aborted = 1'b1;
		end
		trace_done = (fd == 0);

		repeat (8) @(posedge i_clk);
		i_rst <= 1'b0;

		rec_count = 0;
		while (!trace_done && rec_count < REC_LIMIT)
		begin
			rec_count++;
			code = $fscanf(fd, " %c", op);
			if (code != 1)
				trace_done = 1'b1;
			else
				run_record(op);
		end
		if (fd != 0)
			$fclose(fd);

		$display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
		if (run_aborted || error_count != 0 || check_count == 0)
			$display("RESULT: FAIL");
		else
			$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/hdmi_to_vga_trace.txt
# K red_dly grn_dly blu_dly | R count red grn blu (hex words) | T test_id
# E count red grn blu (hex bytes) | S vsync hsync | D count hdr data last
K 0 0 0
R 24 354 354 354
T 1
E 8 ef fe 11
E 8 44 01 00
S 0 0
R 10 354 0ab 354
R 2 2cc 133 2cc
R 8 2f0 1aa 10f
R 8 3c3 055 100
R 16 354 354 354
T 2
E 10 fe 44 ef
S 1 1
R 10 354 0ab 2ab
R 2 2cc 133 2cc
R 10 1aa 3c3 2f0
R 16 354 354 154
T 3
D 1 1 53 0
D 15 1 a6 0
D 15 0 f1 0
D 1 0 f1 1
R 10 0ab 0ab 354
R 2 133 133 28e
R 1 11e 2e2 171
R 15 19c 18e 271
R 16 2c3 263 19c
R 16 354 354 354
T 4
K 2 1 0
E 8 ef fe 11
E 8 44 01 00
S 0 0
R 10 354 0ab 354
R 2 2cc 133 2cc
R 8 2f0 1aa 10f
R 8 3c3 055 100
R 16 354 354 354
T 5
E 12 00 ef 01
S 0 1
R 10 354 0ab 0ab
R 2 2cc 133 2cc
R 12 100 2f0 055
R 12 354 354 354
T 6

//--- list.f
source/hdmi_rx_pkg.sv
source/tmds_decode.sv
source/channel_deskew.sv
source/vga_output.sv
source/data_island_rx.sv
source/hdmi_to_vga.sv
dv/hdmi_to_vga_tb.sv

//--- source/channel_deskew.sv
////////////////////////////////////////
// Channel deskew
// Finds the video preamble and guards on
// each channel and realigns all three
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module channel_deskew
	import hdmi_rx_pkg::*;
(
	input  wire logic		i_clk,
	input  wire logic		i_rst,
	input  wire logic [CTL_W-1:0]	i_blu_ctl,
	input  wire logic [CTL_W-1:0]	i_grn_ctl,
	input  wire logic [CTL_W-1:0]	i_red_ctl,
	input  wire aux_t		i_blu_aux,
	input  wire aux_t		i_grn_aux,
	input  wire aux_t		i_red_aux,
	input  wire logic [PIX_W-1:0]	i_blu_pix,
	input  wire logic [PIX_W-1:0]	i_grn_pix,
	input  wire logic [PIX_W-1:0]	i_red_pix,
	output logic [CTL_W-1:0]	o_blu_ctl,
	output logic [CTL_W-1:0]	o_grn_ctl,
	output logic [CTL_W-1:0]	o_red_ctl,
	output aux_t			o_blu_aux,
	output aux_t			o_grn_aux,
	output aux_t			o_red_aux,
	output logic [PIX_W-1:0]	o_blu_pix,
	output logic [PIX_W-1:0]	o_grn_pix,
	output logic [PIX_W-1:0]	o_red_pix,
	output logic			o_video_start
);

	// Lane is {ctl, aux, pix}
	localparam int LANE_W = CTL_W + AUX_W + PIX_W;
	// Channel order blue, green, red
	localparam logic [2:0] PRE_ANY = 3'b001;
	localparam logic [CTL_W-1:0] PRE_VAL [3] = '{2'b00, VIDEO_PRE_GRN, VIDEO_PRE_RED};
	// Green guard is 10'h133
	localparam logic [2:0] GUARD_POL = 3'b010;

	logic [LANE_W-1:0]	lane_in [3];
	logic [LANE_W-1:0]	lane_out [3];
	logic [LANE_W-1:0]	dly [3][MAX_SKEW];
	logic [CTL_W-1:0]	ctl_in [3];
	aux_t			aux_in [3];
	logic [2:0]		pre_match, guard_now, pre_start, near;
	logic [PREAMBLE_LEN:0]	ctl_hist [3];
	logic [2:0]		guard_d;
	logic [MAX_SKEW:0]	start_hist [3];
	logic [MAX_SKEW-1:0]	lag [3];

	assign lane_in[0] = {i_blu_ctl, i_blu_aux, i_blu_pix};
	assign lane_in[1] = {i_grn_ctl, i_grn_aux, i_grn_pix};
	assign lane_in[2] = {i_red_ctl, i_red_aux, i_red_pix};

	////////////////////////////////////////
	// Per channel start detection
	////////////////////////////////////////
	always_comb
	begin
		for (int c = 0; c < 3; c++)
		begin
			ctl_in[c] = lane_in[c][LANE_W-1 -: CTL_W];
			aux_in[c] = lane_in[c][PIX_W +: AUX_W];
			// Blue takes any control value
			pre_match[c] = aux_in[c].ctl
				&& (PRE_ANY[c] || ctl_in[c] == PRE_VAL[c]);
			guard_now[c] = aux_in[c].guard
				&& (aux_in[c].data[0] == GUARD_POL[c]);
			// Full preamble, then guard, then guard now
			pre_start[c] = (&ctl_hist[c][PREAMBLE_LEN:1])
				&& guard_d[c] && guard_now[c];
			// Started now or in the skew window
			near[c] = |{start_hist[c][MAX_SKEW-1:0], pre_start[c]};
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			guard_d <= '0;
			o_video_start <= 1'b0;
			for (int c = 0; c < 3; c++)
			begin
				ctl_hist[c] <= '0;
				start_hist[c] <= '0;
				lag[c] <= '0;
			end
		end else
		begin
			guard_d <= guard_now;
			// Every channel near, one of them now
			o_video_start <= (&near) && (|pre_start);
			for (int c = 0; c < 3; c++)
			begin
				ctl_hist[c] <= {ctl_hist[c][PREAMBLE_LEN-1:0], pre_match[c]};
				start_hist[c] <= {start_hist[c][MAX_SKEW-1:0], pre_start[c]};
				// Earlier starts mean longer delay
				if ((&near) && (|pre_start))
					lag[c] <= start_hist[c][MAX_SKEW-1:0];
			end
		end
	end

	////////////////////////////////////////
	// Delay lines and lane select
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		for (int c = 0; c < 3; c++)
		begin
			dly[c][0] <= lane_in[c];
			for (int k = 1; k < MAX_SKEW; k++)
				dly[c][k] <= dly[c][k-1];
			// Latest channel passes straight on
			lane_out[c] <= lane_in[c];
			for (int k = MAX_SKEW - 1; k >= 0; k--)
			begin
				if (lag[c][k])
					lane_out[c] <= dly[c][k];
			end
		end
	end

	assign {o_blu_ctl, o_blu_aux, o_blu_pix} = lane_out[0];
	assign {o_grn_ctl, o_grn_aux, o_grn_pix} = lane_out[1];
	assign {o_red_ctl, o_red_aux, o_red_pix} = lane_out[2];

	// Only one delay tap per channel
	for (genvar g = 0; g < 3; g++)
	begin : g_lag_chk
		a_lag_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
			$onehot0(lag[g]));
	end

endmodule

`default_nettype wire

//--- source/data_island_rx.sv
////////////////////////////////////////
// Data island receiver
// Finds island starts and emits packet
// bytes with header and last flags
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module data_island_rx
	import hdmi_rx_pkg::*;
(
	input  wire logic		i_clk,
	input  wire logic		i_rst,
	input  wire logic [CTL_W-1:0]	i_grn_ctl,
	input  wire logic [CTL_W-1:0]	i_red_ctl,
	input  wire aux_t		i_blu_aux,
	input  wire aux_t		i_grn_aux,
	input  wire aux_t		i_red_aux,
	output logic			o_di_valid,
	output logic			o_di_hdr,
	output logic			o_di_last,
	output logic [PIX_W-1:0]	o_di_data
);

	localparam int CNT_W = $clog2(DI_PACKET_LEN + 1);

	logic			pre_match;
	logic			blu_t4;
	logic			all_t4;
	logic			this_guard;
	logic			last_guard;
	logic			primed;
	logic			in_island;
	logic			take_byte;
	logic			pkt_start;
	logic [PREAMBLE_LEN:0]	prime_hist;
	logic [CNT_W-1:0]	byte_cnt;

	////////////////////////////////////////
	// Island start detection
	////////////////////////////////////////
	// Island preamble triple
	assign pre_match = i_blu_aux.ctl
		&& i_grn_aux.ctl && (i_grn_ctl == ISLAND_PRE)
		&& i_red_aux.ctl && (i_red_ctl == ISLAND_PRE);

	// Blue 10'h2cc decodes as guard, but is nibble 8
	assign blu_t4 = i_blu_aux.terc4 || (i_blu_aux.guard && !i_blu_aux.data[0]);
	assign all_t4 = blu_t4 && i_grn_aux.terc4 && i_red_aux.terc4;

	// Data guard: blue TERC4 11xx, green and red 10'h133
	assign this_guard = i_blu_aux.terc4 && (i_blu_aux.data[3:2] == 2'b11)
		&& i_grn_aux.guard && i_grn_aux.data[0]
		&& i_red_aux.guard && i_red_aux.data[0];

	// Second guard after a full preamble
	assign primed = this_guard && last_guard && (&prime_hist[PREAMBLE_LEN:1]);

	// Bit 3 clear opens a packet
	assign pkt_start = !i_blu_aux.data[3];
	assign take_byte = in_island && all_t4 && (pkt_start || o_di_valid);

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			prime_hist <= '0;
			last_guard <= 1'b0;
			in_island <= 1'b0;
		end else
		begin
			prime_hist <= {prime_hist[PREAMBLE_LEN-1:0], pre_match};
			last_guard <= this_guard;
			// Island holds while TERC4 continues
			in_island <= primed || (in_island && all_t4);
		end
	end

	////////////////////////////////////////
	// Byte stream
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			o_di_valid <= 1'b0;
			o_di_last <= 1'b0;
			byte_cnt <= '0;
		end else
		begin
			o_di_valid <= take_byte;
			o_di_last <= 1'b0;
			if (take_byte && pkt_start)
			begin
				byte_cnt <= CNT_W'(1);
				o_di_last <= (DI_PACKET_LEN == 1);
			end else if (take_byte)
			begin
				byte_cnt <= byte_cnt + 1'b1;
				o_di_last <= (byte_cnt + 1'b1 == CNT_W'(DI_PACKET_LEN));
			end
		end
	end

	// Red nibble high, green low
	always_ff @(posedge i_clk)
	begin
		o_di_data <= {i_red_aux.data, i_grn_aux.data};
		o_di_hdr <= i_blu_aux.data[2];
	end

	a_last_valid: assert property (@(posedge i_clk) disable iff (i_rst)
		o_di_last |-> o_di_valid);

endmodule

`default_nettype wire

//--- source/hdmi_rx_pkg.sv
////////////////////////////////////////
// HDMI receive definitions
// Symbol widths, TMDS code tables and the
// protocol lengths shared by the receiver
////////////////////////////////////////
`default_nettype none

package hdmi_rx_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////
	// One TMDS character
	localparam int SYM_W = 10;
	// One colour component
	localparam int PIX_W = 8;
	// Control pair carried per channel
	localparam int CTL_W = 2;
	// Decoded auxiliary field
	localparam int AUX_W = 7;

	// Auxiliary class of a decoded character
	// Guard data holds the polarity in bit 0
	typedef struct packed {
		logic		guard;
		logic		terc4;
		logic		ctl;
		logic [3:0]	data;
	} aux_t;

	////////////////////////////////////////
	// Code tables
	////////////////////////////////////////
	// Control characters, index is {C1,C0}
	localparam logic [SYM_W-1:0] CTL_CODE_0 = 10'h354;
	localparam logic [SYM_W-1:0] CTL_CODE_1 = 10'h0ab;
	localparam logic [SYM_W-1:0] CTL_CODE_2 = 10'h154;
	localparam logic [SYM_W-1:0] CTL_CODE_3 = 10'h2ab;

	// TERC4 characters, indexed by nibble
	localparam logic [SYM_W-1:0] TERC4_CODES [16] = '{
		10'h29c, 10'h263, 10'h2e4, 10'h2e2,
		10'h171, 10'h11e, 10'h18e, 10'h13c,
		10'h2cc, 10'h139, 10'h19c, 10'h2c6,
		10'h28e, 10'h271, 10'h163, 10'h2c3
	};

	// Guard bands
	// Note 10'h2cc is also TERC4 nibble 8
	localparam logic [SYM_W-1:0] GUARD_POS = 10'h2cc;
	localparam logic [SYM_W-1:0] GUARD_NEG = 10'h133;

	////////////////////////////////////////
	// Protocol lengths and preambles
	////////////////////////////////////////
	// Shortest preamble before guards
	localparam int PREAMBLE_LEN = 8;
	// Control run that ends a video period
	localparam int CTL_SYNC_LEN = 12;
	// Largest channel skew in cycles
	localparam int MAX_SKEW = 2;
	// Bytes in one island packet
	localparam int DI_PACKET_LEN = 32;

	// Video preamble, {CTL1,CTL0} and {CTL3,CTL2}
	localparam logic [CTL_W-1:0] VIDEO_PRE_GRN = 2'b01;
	localparam logic [CTL_W-1:0] VIDEO_PRE_RED = 2'b00;
	// Island preamble on green and red
	localparam logic [CTL_W-1:0] ISLAND_PRE = 2'b01;

endpackage

`default_nettype wire

//--- source/hdmi_to_vga.sv
////////////////////////////////////////
// HDMI to VGA converter
// Decodes, aligns and converts three
// TMDS channels to a pixel stream
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module hdmi_to_vga
	import hdmi_rx_pkg::*;
#(
	parameter bit OPT_DATA_ISLAND = 1'b1
) (
	input  wire logic		i_clk,
	input  wire logic		i_rst,
	input  wire logic [SYM_W-1:0]	i_hdmi_red,
	input  wire logic [SYM_W-1:0]	i_hdmi_grn,
	input  wire logic [SYM_W-1:0]	i_hdmi_blu,
	output logic			o_pix_valid,
	output logic			o_vsync,
	output logic			o_hsync,
	output logic [PIX_W-1:0]	o_vga_red,
	output logic [PIX_W-1:0]	o_vga_green,
	output logic [PIX_W-1:0]	o_vga_blue,
	output logic			o_di_valid,
	output logic			o_di_hdr,
	output logic			o_di_last,
	output logic [PIX_W-1:0]	o_di_data
);

	// Decoded, still skewed
	logic [CTL_W-1:0]	u_blu_ctl, u_grn_ctl, u_red_ctl;
	aux_t			u_blu_aux, u_grn_aux, u_red_aux;
	logic [PIX_W-1:0]	u_blu_pix, u_grn_pix, u_red_pix;
	// Aligned channels
	logic [CTL_W-1:0]	s_blu_ctl, s_grn_ctl, s_red_ctl;
	aux_t			s_blu_aux, s_grn_aux, s_red_aux;
	logic [PIX_W-1:0]	s_blu_pix, s_grn_pix, s_red_pix;
	logic			video_start;

	////////////////////////////////////////
	// Decode and align
	////////////////////////////////////////
	tmds_decode u_dec_blu (.i_clk, .i_rst, .i_word(i_hdmi_blu),
		.o_ctl(u_blu_ctl), .o_aux(u_blu_aux), .o_pix(u_blu_pix));
	tmds_decode u_dec_grn (.i_clk, .i_rst, .i_word(i_hdmi_grn),
		.o_ctl(u_grn_ctl), .o_aux(u_grn_aux), .o_pix(u_grn_pix));
	tmds_decode u_dec_red (.i_clk, .i_rst, .i_word(i_hdmi_red),
		.o_ctl(u_red_ctl), .o_aux(u_red_aux), .o_pix(u_red_pix));

	channel_deskew u_deskew (.i_clk, .i_rst,
		.i_blu_ctl(u_blu_ctl), .i_grn_ctl(u_grn_ctl), .i_red_ctl(u_red_ctl),
		.i_blu_aux(u_blu_aux), .i_grn_aux(u_grn_aux), .i_red_aux(u_red_aux),
		.i_blu_pix(u_blu_pix), .i_grn_pix(u_grn_pix), .i_red_pix(u_red_pix),
		.o_blu_ctl(s_blu_ctl), .o_grn_ctl(s_grn_ctl), .o_red_ctl(s_red_ctl),
		.o_blu_aux(s_blu_aux), .o_grn_aux(s_grn_aux), .o_red_aux(s_red_aux),
		.o_blu_pix(s_blu_pix), .o_grn_pix(s_grn_pix), .o_red_pix(s_red_pix),
		.o_video_start(video_start));

	////////////////////////////////////////
	// Pixel and packet outputs
	////////////////////////////////////////
	vga_output u_vga (.i_clk, .i_rst, .i_blu_ctl(s_blu_ctl),
		.i_blu_aux(s_blu_aux), .i_grn_aux(s_grn_aux), .i_red_aux(s_red_aux),
		.i_blu_pix(s_blu_pix), .i_grn_pix(s_grn_pix), .i_red_pix(s_red_pix),
		.i_video_start(video_start), .o_pix_valid, .o_vsync, .o_hsync,
		.o_vga_red, .o_vga_green, .o_vga_blue);

	if (OPT_DATA_ISLAND)
	begin : g_island
		data_island_rx u_island (.i_clk, .i_rst,
			.i_grn_ctl(s_grn_ctl), .i_red_ctl(s_red_ctl),
			.i_blu_aux(s_blu_aux), .i_grn_aux(s_grn_aux), .i_red_aux(s_red_aux),
			.o_di_valid, .o_di_hdr, .o_di_last, .o_di_data);
	end else
	begin : g_no_island
		// Island stream stays idle
		assign o_di_valid = 1'b0;
		assign o_di_hdr = 1'b0;
		assign o_di_last = 1'b0;
		assign o_di_data = '0;
	end

endmodule

`default_nettype wire

//--- source/tmds_decode.sv
////////////////////////////////////////
// TMDS character decoder
// Classifies one 10-bit word as control,
// guard, TERC4 or 8-bit video data
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tmds_decode
	import hdmi_rx_pkg::*;
(
	input  wire logic		i_clk,
	input  wire logic		i_rst,
	input  wire logic [SYM_W-1:0]	i_word,
	output logic [CTL_W-1:0]	o_ctl,
	output aux_t			o_aux,
	output logic [PIX_W-1:0]	o_pix
);

	// Next-cycle decode results
	logic [CTL_W-1:0]	dec_ctl;
	aux_t			dec_aux;
	logic [PIX_W-1:0]	dec_pix;
	// Data bits after conditional inversion
	logic [PIX_W-1:0]	inv;

	////////////////////////////////////////
	// Video data decode
	////////////////////////////////////////
	always_comb
	begin
		// Bit 9 flags an inverted payload
		inv = i_word[9] ? ~i_word[PIX_W-1:0] : i_word[PIX_W-1:0];
		dec_pix[0] = inv[0];
		// Bit 8 picks XOR or XNOR chain
		for (int i = 1; i < PIX_W; i++)
		begin
			if (i_word[8])
				dec_pix[i] = inv[i] ^ inv[i-1];
			else
				dec_pix[i] = ~(inv[i] ^ inv[i-1]);
		end
	end

	////////////////////////////////////////
	// Symbol classification
	////////////////////////////////////////
	always_comb
	begin
		dec_ctl = '0;
		dec_aux = '0;

		// Control characters
		case (i_word)
		CTL_CODE_0: begin dec_aux.ctl = 1'b1; dec_ctl = 2'b00; end
		CTL_CODE_1: begin dec_aux.ctl = 1'b1; dec_ctl = 2'b01; end
		CTL_CODE_2: begin dec_aux.ctl = 1'b1; dec_ctl = 2'b10; end
		CTL_CODE_3: begin dec_aux.ctl = 1'b1; dec_ctl = 2'b11; end
		default: dec_ctl = '0;
		endcase

		// TERC4 table search
		// low two bits carry sync on blue in islands
		for (int k = 0; k < 16; k++)
		begin
			if (i_word == TERC4_CODES[k])
			begin
				dec_aux.terc4 = 1'b1;
				dec_aux.data = k[3:0];
				dec_ctl = k[1:0];
			end
		end

		// Guards win over TERC4
		// 10'h2cc keeps its TERC4 nibble 8, polarity 0
		if (i_word == GUARD_POS)
		begin
			dec_aux.guard = 1'b1;
			dec_aux.terc4 = 1'b0;
		end else if (i_word == GUARD_NEG)
		begin
			dec_aux.guard = 1'b1;
			dec_aux.data = 4'h1;
		end
	end

	////////////////////////////////////////
	// Output registers
	////////////////////////////////////////
	// Class flags
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			o_ctl <= '0;
			o_aux <= '0;
		end else
		begin
			o_ctl <= dec_ctl;
			o_aux <= dec_aux;
		end
	end

	// Pixel byte
	always_ff @(posedge i_clk)
		o_pix <= dec_pix;

	// Class flags stay mutually exclusive
	a_one_class: assert property (@(posedge i_clk) disable iff (i_rst)
		$onehot0({o_aux.guard, o_aux.terc4, o_aux.ctl}));

endmodule

`default_nettype wire

//--- source/vga_output.sv
////////////////////////////////////////
// VGA output stage
// Tracks the video period and registers
// pixels, valid and sync
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module vga_output
	import hdmi_rx_pkg::*;
(
	input  wire logic		i_clk,
	input  wire logic		i_rst,
	input  wire logic [CTL_W-1:0]	i_blu_ctl,
	input  wire aux_t		i_blu_aux,
	input  wire aux_t		i_grn_aux,
	input  wire aux_t		i_red_aux,
	input  wire logic [PIX_W-1:0]	i_blu_pix,
	input  wire logic [PIX_W-1:0]	i_grn_pix,
	input  wire logic [PIX_W-1:0]	i_red_pix,
	input  wire logic		i_video_start,
	output logic			o_pix_valid,
	output logic			o_vsync,
	output logic			o_hsync,
	output logic [PIX_W-1:0]	o_vga_red,
	output logic [PIX_W-1:0]	o_vga_green,
	output logic [PIX_W-1:0]	o_vga_blue
);

	localparam int RUN_W = $clog2(CTL_SYNC_LEN);

	logic			all_ctl;
	logic			ctl_sync;
	logic			video_guard;
	logic			blu_sync_src;
	logic			video_period;
	logic [RUN_W-1:0]	run_cnt;

	////////////////////////////////////////
	// Symbol classes
	////////////////////////////////////////
	// Control on every channel is non-video
	assign all_ctl = i_blu_aux.ctl && i_grn_aux.ctl && i_red_aux.ctl;

	// Video guard triple
	assign video_guard = i_blu_aux.guard && !i_blu_aux.data[0]
		&& i_grn_aux.guard && i_red_aux.guard;

	// Blue carries sync in control or TERC4
	// 10'h2cc counts as TERC4 nibble 8 here
	assign blu_sync_src = i_blu_aux.ctl || i_blu_aux.terc4
		|| (i_blu_aux.guard && !i_blu_aux.data[0]);

	// Twelfth control in a row
	assign ctl_sync = all_ctl && (run_cnt == RUN_W'(CTL_SYNC_LEN - 1));

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			run_cnt <= '0;
		else if (!all_ctl)
			run_cnt <= '0;
		else if (run_cnt != RUN_W'(CTL_SYNC_LEN - 1))
			run_cnt <= run_cnt + 1'b1;
	end

	////////////////////////////////////////
	// Video period and outputs
	////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			video_period <= 1'b0;
		else if (ctl_sync)
			video_period <= 1'b0;
		else if (i_video_start)
			video_period <= 1'b1;
		else if (all_ctl)
			video_period <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			o_pix_valid <= 1'b0;
			o_vsync <= 1'b0;
			o_hsync <= 1'b0;
		end else
		begin
			o_pix_valid <= video_period && !all_ctl;
			// Sync only outside video, skipping guards
			if (blu_sync_src && !video_guard && (!video_period || all_ctl))
			begin
				o_vsync <= i_blu_ctl[1];
				o_hsync <= i_blu_ctl[0];
			end
		end
	end

	// Pixel data
	always_ff @(posedge i_clk)
	begin
		o_vga_red <= i_red_pix;
		o_vga_green <= i_grn_pix;
		o_vga_blue <= i_blu_pix;
	end

endmodule

`default_nettype wire
